// File: design/bp_pkg.sv
package bp_pkg;

    // datapath
    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // branch target buffer, index from pc[4:2]
    localparam int BTB_INDEX_BITS = 3;
    localparam int BTB_ENTRIES = 1 << BTB_INDEX_BITS;
    localparam int BTB_TAG_BITS = XLEN - BTB_INDEX_BITS - 2;   // pc[31:5]

    // global history and pattern history table
    localparam int HISTORY_DEPTH = 4;
    localparam int PHT_ENTRIES = 1 << HISTORY_DEPTH;
    localparam logic [1:0] PHT_INIT = 2'b01;                   // weakly not taken

    // control-flow kind codes
    localparam int CF_KIND_W = 2;
    localparam logic [CF_KIND_W-1:0] CF_BR = 2'd0;
    localparam logic [CF_KIND_W-1:0] CF_JAL = 2'd1;
    localparam logic [CF_KIND_W-1:0] CF_JALR = 2'd2;

    // performance counters
    localparam int PERF_COUNTER_WIDTH = 32;

    // register map of the AXI4-Lite slave
    localparam int REG_ADDR_W = 4;
    localparam logic [REG_ADDR_W-1:0] ADDR_CF_COUNT = 4'h0;
    localparam logic [REG_ADDR_W-1:0] ADDR_CORRECT_COUNT = 4'h4;
    localparam logic [REG_ADDR_W-1:0] ADDR_HISTORY = 4'h8;

    // AXI response codes
    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

endpackage : bp_pkg

// File: design/btb.sv
module btb (
    input  logic                          clk,
    input  logic                          rst_n,

    // lookup at the fetch pc
    input  logic [bp_pkg::XLEN-1:0]       fetch_pc,

    // update from a resolved control-flow instruction
    input  logic                          res_valid,
    input  logic [bp_pkg::XLEN-1:0]       res_pc,
    input  logic                          res_taken,
    input  logic [bp_pkg::CF_KIND_W-1:0]  res_kind,
    input  logic [bp_pkg::XLEN-1:0]       res_target,

    output logic                          hit,
    output logic [bp_pkg::CF_KIND_W-1:0]  hit_kind,
    output logic [bp_pkg::XLEN-1:0]       hit_target
);
    import bp_pkg::*;

    logic [BTB_ENTRIES-1:0]    valid_q;
    logic [BTB_TAG_BITS-1:0]   tag_q    [BTB_ENTRIES];
    logic [CF_KIND_W-1:0]      kind_q   [BTB_ENTRIES];
    logic [XLEN-1:0]           target_q [BTB_ENTRIES];

    logic [BTB_INDEX_BITS-1:0] rd_idx;
    logic [BTB_TAG_BITS-1:0]   rd_tag;
    logic [BTB_INDEX_BITS-1:0] wr_idx;
    logic [BTB_TAG_BITS-1:0]   wr_tag;
    logic                      wr_en;

    // pc[1:0] never takes part, instructions are word aligned
    assign rd_idx = fetch_pc[BTB_INDEX_BITS+1:2];
    assign rd_tag = fetch_pc[XLEN-1:BTB_INDEX_BITS+2];
    assign wr_idx = res_pc[BTB_INDEX_BITS+1:2];
    assign wr_tag = res_pc[XLEN-1:BTB_INDEX_BITS+2];

    assign wr_en = res_valid && res_taken;     // only taken transfers allocate

    // combinational lookup, sees contents before a same-cycle write
    assign hit        = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign hit_kind   = kind_q[rd_idx];
    assign hit_target = target_q[rd_idx];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // entry payload, overwritten on alias
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= wr_tag;
            kind_q[wr_idx]   <= res_kind;
            target_q[wr_idx] <= res_target;
        end
    end

endmodule : btb

// File: design/direction_predictor.sv
module direction_predictor (
    input  logic                              clk,
    input  logic                              rst_n,

    // resolve side
    input  logic                              res_valid,
    input  logic [bp_pkg::CF_KIND_W-1:0]      res_kind,
    input  logic                              res_taken,
    input  logic [bp_pkg::HISTORY_DEPTH-1:0]  res_hist,

    output logic                              predict_taken,
    output logic [bp_pkg::HISTORY_DEPTH-1:0]  hist
);
    import bp_pkg::*;

    logic [HISTORY_DEPTH-1:0] ghr_q;
    logic [1:0]               pht_q [PHT_ENTRIES];

    logic                     br_update;
    logic [1:0]               ctr_cur;

    assign br_update = res_valid && (res_kind == CF_BR);   // jumps leave history alone
    assign ctr_cur   = pht_q[res_hist];

    // msb of the counter selects taken
    assign predict_taken = pht_q[ghr_q][1];
    assign hist          = ghr_q;

    // newest outcome enters at bit 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ghr_q <= '0;
        end else if (br_update) begin
            ghr_q <= {ghr_q[HISTORY_DEPTH-2:0], res_taken};
        end
    end

    // counter trained at the history the branch was predicted with
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                pht_q[i] <= PHT_INIT;
            end
        end else if (br_update) begin
            if (res_taken && (ctr_cur != 2'b11)) begin
                pht_q[res_hist] <= ctr_cur + 2'b01;
            end else if (!res_taken && (ctr_cur != 2'b00)) begin
                pht_q[res_hist] <= ctr_cur - 2'b01;
            end
        end
    end

endmodule : direction_predictor

// File: design/fetch_pc_unit.sv
module fetch_pc_unit (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              fetch_ready,

    // predictor results for the current fetch pc
    input  logic                              btb_hit,
    input  logic [bp_pkg::CF_KIND_W-1:0]      btb_kind,
    input  logic [bp_pkg::XLEN-1:0]           btb_target,
    input  logic                              predict_taken,
    input  logic [bp_pkg::HISTORY_DEPTH-1:0]  hist,

    // resolve side
    input  logic                              res_valid,
    input  logic [bp_pkg::XLEN-1:0]           res_pc,
    input  logic                              res_taken,
    input  logic [bp_pkg::XLEN-1:0]           res_target,
    input  logic [bp_pkg::XLEN-1:0]           res_pred_next,

    output logic [bp_pkg::XLEN-1:0]           fetch_pc,
    output logic [bp_pkg::XLEN-1:0]           fetch_pred_next,
    output logic [bp_pkg::HISTORY_DEPTH-1:0]  fetch_hist,
    output logic                              cf_retire,
    output logic                              cf_correct
);
    import bp_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] actual_next;
    logic            take_target;
    logic            mispredict;

    assign pc_plus4 = pc_q + XLEN'(4);

    // jumps always follow the btb, branches only when the pht agrees
    always_comb begin
        take_target = 1'b0;
        if (btb_hit) begin
            case (btb_kind)
                CF_JAL, CF_JALR: take_target = 1'b1;
                CF_BR:           take_target = predict_taken;
                default:         take_target = 1'b0;
            endcase
        end
    end

    assign fetch_pred_next = take_target ? btb_target : pc_plus4;
    assign fetch_hist      = hist;     // travels with the instruction
    assign fetch_pc        = pc_q;

    // check the carried prediction against the real outcome
    assign actual_next = res_taken ? res_target : (res_pc + XLEN'(4));
    assign mispredict  = res_valid && (actual_next != res_pred_next);

    assign cf_retire  = res_valid;
    assign cf_correct = res_valid && !mispredict;

    // redirect wins over back-pressure
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (mispredict) begin
            pc_q <= actual_next;
        end else if (fetch_ready) begin
            pc_q <= fetch_pred_next;
        end
    end

endmodule : fetch_pc_unit

// File: design/bp_perf_regs.sv
module bp_perf_regs (
    input  logic                              clk,
    input  logic                              rst_n,

    // event strobes and live history
    input  logic                              cf_retire,
    input  logic                              cf_correct,
    input  logic [bp_pkg::HISTORY_DEPTH-1:0]  hist,

    // AXI4-Lite write address
    input  logic                              s_awvalid,
    output logic                              s_awready,
    input  logic [bp_pkg::REG_ADDR_W-1:0]     s_awaddr,

    // AXI4-Lite write data
    input  logic                              s_wvalid,
    output logic                              s_wready,
    input  logic [bp_pkg::XLEN-1:0]           s_wdata,
    input  logic [3:0]                        s_wstrb,

    // AXI4-Lite write response
    output logic                              s_bvalid,
    input  logic                              s_bready,
    output logic [1:0]                        s_bresp,

    // AXI4-Lite read address
    input  logic                              s_arvalid,
    output logic                              s_arready,
    input  logic [bp_pkg::REG_ADDR_W-1:0]     s_araddr,

    // AXI4-Lite read data
    output logic                              s_rvalid,
    input  logic                              s_rready,
    output logic [bp_pkg::XLEN-1:0]           s_rdata,
    output logic [1:0]                        s_rresp
);
    import bp_pkg::*;

    logic [PERF_COUNTER_WIDTH-1:0] cf_count;
    logic [PERF_COUNTER_WIDTH-1:0] correct_count;

    logic init_done;
    logic rd_accept;
    logic wr_accept;

    // both counters wrap at full width
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cf_count      <= '0;
            correct_count <= '0;
        end else begin
            if (cf_retire) begin
                cf_count <= cf_count + PERF_COUNTER_WIDTH'(1);
            end
            if (cf_correct) begin
                correct_count <= correct_count + PERF_COUNTER_WIDTH'(1);
            end
        end
    end

    // keeps every ready low in the first cycle out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init_done <= 1'b0;
        end else begin
            init_done <= 1'b1;
        end
    end

    // read path, one outstanding response
    assign s_arready = init_done && !s_rvalid;
    assign rd_accept = s_arvalid && s_arready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_rvalid <= 1'b0;
        end else if (rd_accept) begin
            s_rvalid <= 1'b1;
        end else if (s_rready) begin
            s_rvalid <= 1'b0;
        end
    end

    // data sampled at the address handshake
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            case (s_araddr)
                ADDR_CF_COUNT: begin
                    s_rdata <= cf_count;
                    s_rresp <= AXI_RESP_OKAY;
                end
                ADDR_CORRECT_COUNT: begin
                    s_rdata <= correct_count;
                    s_rresp <= AXI_RESP_OKAY;
                end
                ADDR_HISTORY: begin
                    s_rdata <= {{(XLEN-HISTORY_DEPTH){1'b0}}, hist};
                    s_rresp <= AXI_RESP_OKAY;
                end
                default: begin
                    s_rdata <= '0;
                    s_rresp <= AXI_RESP_SLVERR;   // unmapped
                end
            endcase
        end
    end

    // write path, AW and W taken together then refused
    assign s_awready = init_done && !s_bvalid && s_awvalid && s_wvalid;
    assign s_wready  = s_awready;
    assign wr_accept = s_awvalid && s_awready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s_bvalid <= 1'b0;
        end else if (wr_accept) begin
            s_bvalid <= 1'b1;
        end else if (s_bready) begin
            s_bvalid <= 1'b0;
        end
    end

    assign s_bresp = AXI_RESP_SLVERR;     // counters are read only

endmodule : bp_perf_regs

// File: design/fetch_predictor.sv
module fetch_predictor (
    input  logic                              clk,
    input  logic                              rst_n,

    // fetch side
    input  logic                              fetch_ready,
    output logic [bp_pkg::XLEN-1:0]           fetch_pc,
    output logic [bp_pkg::XLEN-1:0]           fetch_pred_next,
    output logic [bp_pkg::HISTORY_DEPTH-1:0]  fetch_hist,

    // resolve side from decode
    input  logic                              res_valid,
    input  logic [bp_pkg::XLEN-1:0]           res_pc,
    input  logic [bp_pkg::CF_KIND_W-1:0]      res_kind,
    input  logic                              res_taken,
    input  logic [bp_pkg::XLEN-1:0]           res_target,
    input  logic [bp_pkg::XLEN-1:0]           res_pred_next,
    input  logic [bp_pkg::HISTORY_DEPTH-1:0]  res_hist,

    // AXI4-Lite slave
    input  logic                              s_awvalid,
    output logic                              s_awready,
    input  logic [bp_pkg::REG_ADDR_W-1:0]     s_awaddr,
    input  logic                              s_wvalid,
    output logic                              s_wready,
    input  logic [bp_pkg::XLEN-1:0]           s_wdata,
    input  logic [3:0]                        s_wstrb,
    output logic                              s_bvalid,
    input  logic                              s_bready,
    output logic [1:0]                        s_bresp,
    input  logic                              s_arvalid,
    output logic                              s_arready,
    input  logic [bp_pkg::REG_ADDR_W-1:0]     s_araddr,
    output logic                              s_rvalid,
    input  logic                              s_rready,
    output logic [bp_pkg::XLEN-1:0]           s_rdata,
    output logic [1:0]                        s_rresp
);
    import bp_pkg::*;

    logic                     btb_hit;
    logic [CF_KIND_W-1:0]     btb_kind;
    logic [XLEN-1:0]          btb_target;
    logic                     predict_taken;
    logic [HISTORY_DEPTH-1:0] hist;
    logic                     cf_retire;
    logic                     cf_correct;

    btb btb (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_pc   (fetch_pc),
        .res_valid  (res_valid),
        .res_pc     (res_pc),
        .res_taken  (res_taken),
        .res_kind   (res_kind),
        .res_target (res_target),
        .hit        (btb_hit),
        .hit_kind   (btb_kind),
        .hit_target (btb_target)
    );

    direction_predictor direction_predictor (
        .clk           (clk),
        .rst_n         (rst_n),
        .res_valid     (res_valid),
        .res_kind      (res_kind),
        .res_taken     (res_taken),
        .res_hist      (res_hist),
        .predict_taken (predict_taken),
        .hist          (hist)
    );

    fetch_pc_unit fetch_pc_unit (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_ready     (fetch_ready),
        .btb_hit         (btb_hit),
        .btb_kind        (btb_kind),
        .btb_target      (btb_target),
        .predict_taken   (predict_taken),
        .hist            (hist),
        .res_valid       (res_valid),
        .res_pc          (res_pc),
        .res_taken       (res_taken),
        .res_target      (res_target),
        .res_pred_next   (res_pred_next),
        .fetch_pc        (fetch_pc),
        .fetch_pred_next (fetch_pred_next),
        .fetch_hist      (fetch_hist),
        .cf_retire       (cf_retire),
        .cf_correct      (cf_correct)
    );

    bp_perf_regs bp_perf_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .cf_retire  (cf_retire),
        .cf_correct (cf_correct),
        .hist       (hist),
        .s_awvalid  (s_awvalid),
        .s_awready  (s_awready),
        .s_awaddr   (s_awaddr),
        .s_wvalid   (s_wvalid),
        .s_wready   (s_wready),
        .s_wdata    (s_wdata),
        .s_wstrb    (s_wstrb),
        .s_bvalid   (s_bvalid),
        .s_bready   (s_bready),
        .s_bresp    (s_bresp),
        .s_arvalid  (s_arvalid),
        .s_arready  (s_arready),
        .s_araddr   (s_araddr),
        .s_rvalid   (s_rvalid),
        .s_rready   (s_rready),
        .s_rdata    (s_rdata),
        .s_rresp    (s_rresp)
    );

endmodule : fetch_predictor

// File: verification/fetch_predictor_asserts.sv
module fetch_predictor_asserts (
    input logic                              clk,
    input logic                              rst_n,
    input logic                              fetch_ready,
    input logic [bp_pkg::XLEN-1:0]           fetch_pc,
    input logic [bp_pkg::XLEN-1:0]           fetch_pred_next,
    input logic [bp_pkg::HISTORY_DEPTH-1:0]  fetch_hist,
    input logic                              res_valid,
    input logic [bp_pkg::XLEN-1:0]           res_pc,
    input logic [bp_pkg::CF_KIND_W-1:0]      res_kind,
    input logic                              res_taken,
    input logic [bp_pkg::XLEN-1:0]           res_target,
    input logic [bp_pkg::XLEN-1:0]           res_pred_next,
    input logic [bp_pkg::HISTORY_DEPTH-1:0]  res_hist,
    input logic                              s_awvalid,
    input logic                              s_awready,
    input logic                              s_wvalid,
    input logic                              s_wready,
    input logic                              s_bvalid,
    input logic                              s_bready,
    input logic [1:0]                        s_bresp,
    input logic                              s_arvalid,
    input logic                              s_arready,
    input logic [bp_pkg::REG_ADDR_W-1:0]     s_araddr,
    input logic                              s_rvalid,
    input logic                              s_rready,
    input logic [bp_pkg::XLEN-1:0]           s_rdata,
    input logic [1:0]                        s_rresp
);
    import bp_pkg::*;

    int unsigned fail_count = 0;

    // shadow predictor state
    logic [BTB_ENTRIES-1:0]        sh_valid;
    logic [BTB_TAG_BITS-1:0]       sh_tag    [BTB_ENTRIES];
    logic [CF_KIND_W-1:0]          sh_kind   [BTB_ENTRIES];
    logic [XLEN-1:0]               sh_target [BTB_ENTRIES];
    logic [HISTORY_DEPTH-1:0]      sh_ghr;
    logic [1:0]                    sh_pht    [PHT_ENTRIES];
    logic [PERF_COUNTER_WIDTH-1:0] sh_cf;
    logic [PERF_COUNTER_WIDTH-1:0] sh_correct;

    logic [BTB_INDEX_BITS-1:0]     fetch_idx;
    logic                          sh_hit;
    logic [XLEN-1:0]               exp_next;
    logic [XLEN-1:0]               actual_next;
    logic                          mispredict;
    logic [XLEN-1:0]               prev_actual;
    logic [XLEN-1:0]               prev_pred;
    logic [XLEN-1:0]               exp_rdata;
    logic [1:0]                    exp_rresp;

    assign fetch_idx = fetch_pc[BTB_INDEX_BITS+1:2];
    assign sh_hit    = sh_valid[fetch_idx] && (sh_tag[fetch_idx] == fetch_pc[XLEN-1:5]);

    always_comb begin
        exp_next = fetch_pc + 32'd4;      // fall through by default
        if (sh_hit && ((sh_kind[fetch_idx] == CF_JAL) || (sh_kind[fetch_idx] == CF_JALR))) begin
            exp_next = sh_target[fetch_idx];
        end else if (sh_hit && (sh_kind[fetch_idx] == CF_BR) && (sh_pht[sh_ghr] >= 2'd2)) begin
            exp_next = sh_target[fetch_idx];
        end
    end

    assign actual_next = res_taken ? res_target : (res_pc + 32'd4);
    assign mispredict  = res_valid && (actual_next != res_pred_next);

    always_ff @(posedge clk) begin
        prev_actual <= actual_next;
        prev_pred   <= fetch_pred_next;
        if (!rst_n) begin
            sh_valid   <= '0;
            sh_ghr     <= '0;
            sh_cf      <= '0;
            sh_correct <= '0;
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                sh_pht[i] <= PHT_INIT;
            end
        end else if (res_valid) begin
            sh_cf <= sh_cf + 1;
            if (!mispredict) begin
                sh_correct <= sh_correct + 1;
            end
            if (res_taken) begin
                sh_valid[res_pc[BTB_INDEX_BITS+1:2]]  <= 1'b1;
                sh_tag[res_pc[BTB_INDEX_BITS+1:2]]    <= res_pc[XLEN-1:5];
                sh_kind[res_pc[BTB_INDEX_BITS+1:2]]   <= res_kind;
                sh_target[res_pc[BTB_INDEX_BITS+1:2]] <= res_target;
            end
            if (res_kind == CF_BR) begin
                sh_ghr <= {sh_ghr[HISTORY_DEPTH-2:0], res_taken};
                if (res_taken && (sh_pht[res_hist] != 2'd3)) begin
                    sh_pht[res_hist] <= sh_pht[res_hist] + 2'd1;
                end else if (!res_taken && (sh_pht[res_hist] != 2'd0)) begin
                    sh_pht[res_hist] <= sh_pht[res_hist] - 2'd1;
                end
            end
        end
    end

    // expected read response, latched at the address handshake
    always_ff @(posedge clk) begin
        if (s_arvalid && s_arready) begin
            exp_rresp <= AXI_RESP_OKAY;
            case (s_araddr)
                ADDR_CF_COUNT:      exp_rdata <= sh_cf;
                ADDR_CORRECT_COUNT: exp_rdata <= sh_correct;
                ADDR_HISTORY:       exp_rdata <= XLEN'(sh_ghr);
                default: begin
                    exp_rdata <= '0;
                    exp_rresp <= AXI_RESP_SLVERR;
                end
            endcase
        end
    end

    reset_state: assert property (@(posedge clk)
        (rst_n && !$past(rst_n)) |-> (fetch_pc == RESET_PC) && !s_rvalid && !s_bvalid
                                     && !s_arready)
    else begin
        fail_count++;
        $error("ERROR fetch_pc=%h s_rvalid=%h s_bvalid=%h s_arready=%h after reset",
            $sampled(fetch_pc), $sampled(s_rvalid), $sampled(s_bvalid), $sampled(s_arready));
    end

    prediction: assert property (@(posedge clk) disable iff (!rst_n)
        (fetch_pred_next == exp_next) && (fetch_hist == sh_ghr))
    else begin
        fail_count++;
        $error("ERROR fetch_pred_next=%h exp %h fetch_hist=%h exp %h",
            $sampled(fetch_pred_next), $sampled(exp_next), $sampled(fetch_hist), $sampled(sh_ghr));
    end

    redirect: assert property (@(posedge clk) disable iff (!rst_n)
        mispredict |=> (fetch_pc == prev_actual))
    else begin
        fail_count++;
        $error("ERROR fetch_pc=%h exp %h on redirect", $sampled(fetch_pc), $sampled(prev_actual));
    end

    advance: assert property (@(posedge clk) disable iff (!rst_n)
        (!mispredict && fetch_ready) |=> (fetch_pc == prev_pred))
    else begin
        fail_count++;
        $error("ERROR fetch_pc=%h exp %h on advance", $sampled(fetch_pc), $sampled(prev_pred));
    end

    stall: assert property (@(posedge clk) disable iff (!rst_n)
        (!mispredict && !fetch_ready) |=> $stable(fetch_pc))
    else begin
        fail_count++;
        $error("ERROR fetch_pc=%h changed under back-pressure", $sampled(fetch_pc));
    end

    read_resp: assert property (@(posedge clk) disable iff (!rst_n)
        s_rvalid |-> !s_arready && (s_rresp == exp_rresp)
                     && ((exp_rresp != AXI_RESP_OKAY) || (s_rdata == exp_rdata)))
    else begin
        fail_count++;
        $error("ERROR s_rdata=%h exp %h s_rresp=%h exp %h s_arready=%h",
            $sampled(s_rdata), $sampled(exp_rdata), $sampled(s_rresp), $sampled(exp_rresp),
            $sampled(s_arready));
    end

    read_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (s_rvalid && !s_rready) |=> s_rvalid && $stable(s_rdata) && $stable(s_rresp))
    else begin
        fail_count++;
        $error("ERROR s_rvalid=%h s_rdata=%h not held", $sampled(s_rvalid), $sampled(s_rdata));
    end

    // AW and W are taken in the same cycle
    write_pair: assert property (@(posedge clk) disable iff (!rst_n)
        (s_awvalid && s_awready) == (s_wvalid && s_wready))
    else begin
        fail_count++;
        $error("ERROR s_awready=%h s_wready=%h at write handshake",
            $sampled(s_awready), $sampled(s_wready));
    end

    write_resp: assert property (@(posedge clk) disable iff (!rst_n)
        (s_awvalid && s_awready) |=> s_bvalid && (s_bresp == AXI_RESP_SLVERR))
    else begin
        fail_count++;
        $error("ERROR s_bvalid=%h s_bresp=%h after write", $sampled(s_bvalid), $sampled(s_bresp));
    end

    write_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (s_bvalid && !s_bready) |=> s_bvalid)
    else begin
        fail_count++;
        $error("ERROR s_bvalid=%h not held while pending", $sampled(s_bvalid));
    end

endmodule : fetch_predictor_asserts

bind fetch_predictor fetch_predictor_asserts asserts (.*);

// File: verification/tb_fetch_predictor.sv
module tb_fetch_predictor;
    import bp_pkg::*;

    localparam int PERIOD       = 4;
    localparam int RESET_CYCLES = 10;
    localparam int N_STIM       = 400;
    localparam int AXI_CYCLES   = 50;    // five transfers, worst case
    localparam int TIMEOUT      = (RESET_CYCLES + N_STIM + AXI_CYCLES) * PERIOD * 2;

    logic                     clk;
    logic                     rst_n;
    logic                     fetch_ready;
    logic [XLEN-1:0]          fetch_pc;
    logic [XLEN-1:0]          fetch_pred_next;
    logic [HISTORY_DEPTH-1:0] fetch_hist;
    logic                     res_valid;
    logic [XLEN-1:0]          res_pc;
    logic [CF_KIND_W-1:0]     res_kind;
    logic                     res_taken;
    logic [XLEN-1:0]          res_target;
    logic [XLEN-1:0]          res_pred_next;
    logic [HISTORY_DEPTH-1:0] res_hist;
    logic                     s_awvalid;
    logic                     s_awready;
    logic [REG_ADDR_W-1:0]    s_awaddr;
    logic                     s_wvalid;
    logic                     s_wready;
    logic [XLEN-1:0]          s_wdata;
    logic [3:0]               s_wstrb;
    logic                     s_bvalid;
    logic                     s_bready;
    logic [1:0]               s_bresp;
    logic                     s_arvalid;
    logic                     s_arready;
    logic [REG_ADDR_W-1:0]    s_araddr;
    logic                     s_rvalid;
    logic                     s_rready;
    logic [XLEN-1:0]          s_rdata;
    logic [1:0]               s_rresp;

    logic [31:0] rand_state;
    logic [31:0] pc_table [8];       // pairs and triples share a btb set

    fetch_predictor dut (.*);

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_cycle();
        logic [31:0] r;
        rand_state = lcg_step(rand_state);
        r = rand_state;
        fetch_ready = (r[31:30] != 2'b00);
        res_valid   = r[29];
        res_kind    = CF_KIND_W'(r[27:20] % 8'd3);
        res_taken   = r[19] || (res_kind != CF_BR);   // jumps always taken
        res_target  = pc_table[r[18:16]];
        if (r[15]) begin
            res_pc        = fetch_pc;                // resolve what fetch just emitted
            res_pred_next = fetch_pred_next;
            res_hist      = fetch_hist;
        end else begin
            res_pc = pc_table[r[14:12]];
            rand_state = lcg_step(rand_state);
            res_pred_next = rand_state[0] ? res_pc + 32'd4 : pc_table[rand_state[3:1]];
            res_hist = rand_state[7:4];
        end
    endtask

    task automatic axi_read(input logic [REG_ADDR_W-1:0] addr);
        s_arvalid = 1'b1;
        s_araddr  = addr;
        #1;
        while (!s_arready) begin
            @(posedge clk);
            #2;
        end
        next_edge();
        s_arvalid = 1'b0;
        rand_state = lcg_step(rand_state);
        repeat (1 + rand_state[1:0]) next_edge();    // response must hold meanwhile
        s_rready = 1'b1;
        #1;
        while (!s_rvalid) begin
            @(posedge clk);
            #2;
        end
        next_edge();
        s_rready = 1'b0;
    endtask

    task automatic axi_write(input logic [REG_ADDR_W-1:0] addr, input logic [XLEN-1:0] data);
        s_awvalid = 1'b1;
        s_awaddr  = addr;
        s_wvalid  = 1'b1;
        s_wdata   = data;
        s_wstrb   = 4'hf;
        #1;
        while (!s_awready) begin
            @(posedge clk);
            #2;
        end
        next_edge();
        s_awvalid = 1'b0;
        s_wvalid  = 1'b0;
        rand_state = lcg_step(rand_state);
        repeat (1 + rand_state[1:0]) next_edge();
        s_bready = 1'b1;
        #1;
        while (!s_bvalid) begin
            @(posedge clk);
            #2;
        end
        next_edge();
        s_bready = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        fetch_ready = 1'b0;
        res_valid = 1'b0;
        res_pc = '0;
        res_kind = CF_BR;
        res_taken = 1'b0;
        res_target = '0;
        res_pred_next = '0;
        res_hist = '0;
        s_awvalid = 1'b0;
        s_awaddr = '0;
        s_wvalid = 1'b0;
        s_wdata = '0;
        s_wstrb = '0;
        s_bready = 1'b0;
        s_arvalid = 1'b0;
        s_araddr = '0;
        s_rready = 1'b0;
        rand_state = 32'h25a4d495;
        pc_table = '{32'h10, 32'h30, 32'h50, 32'h1c, 32'h3c, 32'h04, 32'h24, 32'h08};
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int n = 0; n < N_STIM; n++) begin
            drive_cycle();
            next_edge();
        end
        res_valid = 1'b0;
        fetch_ready = 1'b0;
        axi_read(ADDR_CF_COUNT);
        axi_read(ADDR_CORRECT_COUNT);
        axi_read(ADDR_HISTORY);
        axi_read(4'hc);                          // unmapped
        axi_write(ADDR_CF_COUNT, rand_state);
        repeat (4) next_edge();
        if (dut.asserts.fail_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "assertion failures during the run");
        end
    end

    // first assertion failure ends the run
    initial begin
        wait (dut.asserts.fail_count != 0);
        $display("Test failed");
        $fatal(1, "an assertion on the DUT failed");
    end

    initial begin
        #(TIMEOUT);
        $display("watchdog expired before the stimulus completed");
        $display("Test failed");
        $fatal(1, "timeout");
    end

endmodule : tb_fetch_predictor

// File: filelist.f
design/bp_pkg.sv
design/btb.sv
design/direction_predictor.sv
design/fetch_pc_unit.sv
design/bp_perf_regs.sv
design/fetch_predictor.sv
verification/fetch_predictor_asserts.sv
verification/tb_fetch_predictor.sv

// File: run.sh
#!/bin/sh
# Build and run the fetch predictor testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing -j 0 \
    --top-module tb_fetch_predictor \
    -f filelist.f

output=$(./obj_dir/Vtb_fetch_predictor 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
